//--- verilog/issue_pkg.sv
`default_nettype none

package issue_pkg;

  //////////////////////////////
  // widths.

  localparam int INST_WIDTH  = 32;
  localparam int ADDR_WIDTH  = 32;
  localparam int ID_WIDTH    = 8;
  localparam int OPCODE_BITS = 6;
  localparam int REG_BITS    = 5;

  //////////////////////////////
  // opcodes, group in the top two bits.

  localparam logic [OPCODE_BITS-1:0] OP_NOP   = 6'b000000;
  localparam logic [OPCODE_BITS-1:0] OP_CMP   = 6'b001110;
  localparam logic [OPCODE_BITS-1:0] OP_TEST  = 6'b001111;
  localparam logic [OPCODE_BITS-1:0] OP_CMPI  = 6'b011110;
  localparam logic [OPCODE_BITS-1:0] OP_TESTI = 6'b011111;
  localparam logic [OPCODE_BITS-1:0] OP_LW    = 6'b100000;
  localparam logic [OPCODE_BITS-1:0] OP_SW    = 6'b100001;
  localparam logic [OPCODE_BITS-1:0] OP_JMP   = 6'b110000;

  //////////////////////////////
  // which decoded fields are live.

  typedef logic [2:0] reg_mask_t;

  localparam reg_mask_t MASK_RS0 = 3'b001;
  localparam reg_mask_t MASK_RS1 = 3'b010;
  localparam reg_mask_t MASK_RD  = 3'b100;

  typedef enum logic [1:0] {
    PIPE_ANY    = 2'd0,
    PIPE_BRANCH = 2'd1,  // lane 0.
    PIPE_MEMORY = 2'd2   // lane 1.
  } pipe_t;

  //////////////////////////////
  // rs 25..21, rt 20..16, rd 15..11.

  typedef struct packed {
    logic [OPCODE_BITS-1:0] opcode;
    logic [REG_BITS-1:0]    rs;
    logic [REG_BITS-1:0]    rt;
    logic [REG_BITS-1:0]    rd;
    logic [10:0]            rest;
  } r_fmt_t;

  typedef struct packed {
    logic [OPCODE_BITS-1:0] opcode;
    logic [REG_BITS-1:0]    rs;
    logic [REG_BITS-1:0]    rt;
    logic [15:0]            imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_u;

endpackage

`default_nettype wire

//--- verilog/issue_entry_store.sv
`timescale 1ns/100ps
`default_nettype none

module issue_entry_store import issue_pkg::*; #(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               flush,
  input  logic                                               push0,
  input  logic                                               push1,
  input  logic [INST_WIDTH+ADDR_WIDTH+ID_WIDTH-1:0]          push_data0,
  input  logic [INST_WIDTH+ADDR_WIDTH+ID_WIDTH-1:0]          push_data1,
  input  logic                                               pop0,
  input  logic [$clog2(NUM_ENTRIES)-1:0]                     pop_key0,
  input  logic                                               pop1,
  input  logic [$clog2(NUM_ENTRIES)-1:0]                     pop_key1,
  output logic [NUM_ENTRIES*INST_WIDTH-1:0]                  slot_inst,
  output logic [NUM_ENTRIES*ADDR_WIDTH-1:0]                  slot_pc,
  output logic [NUM_ENTRIES*ID_WIDTH-1:0]                    slot_id,
  output logic [NUM_ENTRIES-1:0]                             slot_valid,
  output logic [$clog2(NUM_ENTRIES):0]                       free,
  output logic                                               stall
);

  localparam int KEY_W  = $clog2(NUM_ENTRIES);
  localparam int DATA_W = INST_WIDTH + ADDR_WIDTH + ID_WIDTH;
  localparam logic [KEY_W:0] DEPTH = (KEY_W+1)'(NUM_ENTRIES);

  logic [DATA_W-1:0]      data     [NUM_ENTRIES];
  logic [DATA_W-1:0]      nxt_data [NUM_ENTRIES];
  logic [KEY_W:0]         count;
  logic [KEY_W:0]         nxt_count;
  logic [NUM_ENTRIES-1:0] popped;

  assign free  = DEPTH - count;
  assign stall = free < (KEY_W+1)'(2);  // current count, pops not counted.

  always_comb begin
    popped = '0;
    if (pop0) begin
      popped[pop_key0] = 1'b1;
    end
    if (pop1) begin
      popped[pop_key1] = 1'b1;
    end
  end

  //////////////////////////////
  // survivors shift down in age order, pushes append.

  always_comb begin
    nxt_data  = data;
    nxt_count = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (slot_valid[i] && !popped[i]) begin
        nxt_data[nxt_count[KEY_W-1:0]] = data[i];
        nxt_count = nxt_count + 1'b1;
      end
    end
    if (push0 && nxt_count < DEPTH) begin
      nxt_data[nxt_count[KEY_W-1:0]] = push_data0;
      nxt_count = nxt_count + 1'b1;
    end
    if (push1 && nxt_count < DEPTH) begin  // lone push1 takes first free slot.
      nxt_data[nxt_count[KEY_W-1:0]] = push_data1;
      nxt_count = nxt_count + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;  // drops same-cycle pushes too.
    end else begin
      count <= nxt_count;
    end
  end

  always_ff @(posedge clk) begin
    data <= nxt_data;
  end

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_slot
    assign slot_valid[g] = count > (KEY_W+1)'(g);
    assign {slot_inst[g*INST_WIDTH +: INST_WIDTH],
            slot_pc[g*ADDR_WIDTH +: ADDR_WIDTH],
            slot_id[g*ID_WIDTH +: ID_WIDTH]} = data[g];
  end

  //////////////////////////////

  a_no_push_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (push0 || push1) |-> !stall);

  // the selector must only name live slots.
  a_pop_live_slot: assert property (@(posedge clk) disable iff (!rst_n)
    (!pop0 || slot_valid[pop_key0]) && (!pop1 || slot_valid[pop_key1]));

endmodule

`default_nettype wire

//--- verilog/reg_decode.sv
`timescale 1ns/100ps
`default_nettype none

module reg_decode import issue_pkg::*; (
  input  logic [INST_WIDTH-1:0] inst,
  output logic [REG_BITS-1:0]   src0,
  output logic [REG_BITS-1:0]   src1,
  output logic [REG_BITS-1:0]   dest,
  output reg_mask_t             mask,
  output pipe_t                 pipe
);

  inst_u word;

  assign word = inst;

  always_comb begin
    src0 = word.r_fmt.rs;
    src1 = word.r_fmt.rt;
    dest = word.r_fmt.rd;
    mask = '0;
    case (word.r_fmt.opcode[5:4])
      2'b00: begin  // register alu.
        if (word.r_fmt.opcode != OP_NOP) begin
          mask = MASK_RS0 | MASK_RS1 | MASK_RD;
        end
      end
      2'b01: begin  // immediate alu writes rt.
        dest = word.i_fmt.rt;
        mask = MASK_RS0 | MASK_RD;
      end
      2'b10: begin
        if (word.i_fmt.opcode == OP_LW) begin
          dest = word.i_fmt.rt;
          mask = MASK_RS0 | MASK_RD;
        end else if (word.i_fmt.opcode == OP_SW) begin
          mask = MASK_RS0 | MASK_RS1;
        end
      end
      default: mask = '0;
    endcase
  end

  always_comb begin
    pipe = PIPE_ANY;
    if (word.r_fmt.opcode[5:4] == 2'b10) begin
      pipe = PIPE_MEMORY;
    end else if (word.r_fmt.opcode[5:4] == 2'b11 || word.r_fmt.opcode == OP_CMP ||
                 word.r_fmt.opcode == OP_TEST || word.r_fmt.opcode == OP_CMPI ||
                 word.r_fmt.opcode == OP_TESTI) begin
      pipe = PIPE_BRANCH;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pair_hazard.sv
`timescale 1ns/100ps
`default_nettype none

module pair_hazard import issue_pkg::*; #(
  parameter int NUM_ENTRIES = 8
) (
  input  logic [NUM_ENTRIES*INST_WIDTH-1:0]          slot_inst,
  input  logic [NUM_ENTRIES*REG_BITS-1:0]            src0,
  input  logic [NUM_ENTRIES*REG_BITS-1:0]            src1,
  input  logic [NUM_ENTRIES*REG_BITS-1:0]            dest,
  input  logic [NUM_ENTRIES*$bits(reg_mask_t)-1:0]   mask,
  input  logic [NUM_ENTRIES-1:0]                     slot_valid,
  input  logic                                       pop0,
  input  logic [$clog2(NUM_ENTRIES)-1:0]             pop_key0,
  output logic [NUM_ENTRIES-1:0]                     eligible
);

  localparam int KEY_W  = $clog2(NUM_ENTRIES);
  localparam int MASK_W = $bits(reg_mask_t);

  logic [OPCODE_BITS-1:0] opcode [NUM_ENTRIES];
  logic [REG_BITS-1:0]    s0     [NUM_ENTRIES];
  logic [REG_BITS-1:0]    s1     [NUM_ENTRIES];
  logic [REG_BITS-1:0]    d      [NUM_ENTRIES];
  reg_mask_t              msk    [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] rs0_v;
  logic [NUM_ENTRIES-1:0] rs1_v;
  logic [NUM_ENTRIES-1:0] rd_v;
  logic [NUM_ENTRIES-1:0] is_branch;
  logic [NUM_ENTRIES-1:0] is_cmp;
  logic [NUM_ENTRIES-1:0] is_mem;
  logic [NUM_ENTRIES-1:0] is_first;
  logic [NUM_ENTRIES-1:0] blocked [NUM_ENTRIES];  // [younger][older].

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_unpack
    assign opcode[g] = slot_inst[g*INST_WIDTH + INST_WIDTH - OPCODE_BITS +: OPCODE_BITS];
    assign s0[g]  = src0[g*REG_BITS +: REG_BITS];
    assign s1[g]  = src1[g*REG_BITS +: REG_BITS];
    assign d[g]   = dest[g*REG_BITS +: REG_BITS];
    assign msk[g] = mask[g*MASK_W +: MASK_W];

    assign rs0_v[g] = |(msk[g] & MASK_RS0);
    assign rs1_v[g] = |(msk[g] & MASK_RS1);
    assign rd_v[g]  = |(msk[g] & MASK_RD);

    assign is_branch[g] = (opcode[g][5:4] == 2'b11) && (opcode[g] != OP_JMP);
    assign is_cmp[g]    = (opcode[g] == OP_CMP) || (opcode[g] == OP_TEST) ||
                          (opcode[g] == OP_CMPI) || (opcode[g] == OP_TESTI);
    assign is_mem[g]    = (opcode[g] == OP_LW) || (opcode[g] == OP_SW);
    assign is_first[g]  = pop0 && (pop_key0 == KEY_W'(g));
  end

  //////////////////////////////
  // only older entries can block.

  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_row
    for (genvar j = 0; j < NUM_ENTRIES; j++) begin : g_col
      if (j < i) begin : g_older
        logic raw;
        logic war;
        logic waw;
        assign raw = rd_v[j] && ((rs0_v[i] && s0[i] == d[j]) || (rs1_v[i] && s1[i] == d[j]));
        assign war = rd_v[i] && ((rs0_v[j] && s0[j] == d[i]) || (rs1_v[j] && s1[j] == d[i]));
        assign waw = rd_v[i] && rd_v[j] && (d[i] == d[j]);
        // war, waw and older branch are fine when j issues this cycle.
        assign blocked[i][j] = slot_valid[j] &&
                               (raw ||
                                (!is_first[j] && (war || waw || is_branch[j])) ||
                                (is_branch[i] && is_cmp[j]) ||
                                (is_cmp[i] && is_branch[j]) ||
                                (is_mem[i] && is_mem[j]));
      end else begin : g_none
        assign blocked[i][j] = 1'b0;
      end
    end
    assign eligible[i] = slot_valid[i] && !(|blocked[i]);
  end

endmodule

`default_nettype wire

//--- verilog/issue_select.sv
`timescale 1ns/100ps
`default_nettype none

module issue_select import issue_pkg::*; #(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [NUM_ENTRIES-1:0]                  slot_valid,
  input  logic [NUM_ENTRIES-1:0]                  eligible,
  input  logic [NUM_ENTRIES*$bits(pipe_t)-1:0]    pipe,
  output logic                                    pop0,
  output logic [$clog2(NUM_ENTRIES)-1:0]          pop_key0,
  output logic                                    pop1,
  output logic [$clog2(NUM_ENTRIES)-1:0]          pop_key1,
  output logic                                    first
);

  localparam int KEY_W  = $clog2(NUM_ENTRIES);
  localparam int PIPE_W = $bits(pipe_t);

  pipe_t                  pipe_of [NUM_ENTRIES];
  pipe_t                  pipe0;
  logic [NUM_ENTRIES-1:0] cand;

  // two of the same dedicated pipe cannot go together.
  function automatic logic pair_ok(pipe_t a, pipe_t b);
    return !((a == PIPE_BRANCH && b == PIPE_BRANCH) ||
             (a == PIPE_MEMORY && b == PIPE_MEMORY));
  endfunction

  // high when the first pick belongs on lane 1.
  function automatic logic pair_swap(pipe_t a, pipe_t b);
    return (a == PIPE_MEMORY && b != PIPE_MEMORY) ||
           (a == PIPE_ANY && b == PIPE_BRANCH);
  endfunction

  //////////////////////////////

  assign pop0     = slot_valid[0];  // oldest always goes.
  assign pop_key0 = '0;
  assign pipe0    = pipe_of[pop_key0];

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_cand
    assign pipe_of[g] = pipe_t'(pipe[g*PIPE_W +: PIPE_W]);
    assign cand[g]    = pop0 && eligible[g] && (pop_key0 != KEY_W'(g)) &&
                        pair_ok(pipe0, pipe_of[g]);
  end

  // lowest candidate wins.
  always_comb begin
    pop1     = 1'b0;
    pop_key1 = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (cand[i]) begin
        pop1     = 1'b1;
        pop_key1 = KEY_W'(i);
      end
    end
  end

  assign first = pop1 ? pair_swap(pipe0, pipe_of[pop_key1])
                      : (pop0 && pipe0 == PIPE_MEMORY);

  //////////////////////////////

  a_keys_differ: assert property (@(posedge clk) disable iff (!rst_n)
    (pop0 && pop1) |-> (pop_key0 != pop_key1));

  a_one_memory: assert property (@(posedge clk) disable iff (!rst_n)
    (pop0 && pop1) |-> !(pipe0 == PIPE_MEMORY && pipe_of[pop_key1] == PIPE_MEMORY));

endmodule

`default_nettype wire

//--- verilog/issue_top.sv
`timescale 1ns/100ps
`default_nettype none

module issue_top import issue_pkg::*; #(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,
  input  logic                           push0,
  input  logic                           push1,
  input  logic [INST_WIDTH-1:0]          inst0,
  input  logic [INST_WIDTH-1:0]          inst1,
  input  logic [ADDR_WIDTH-1:0]          pc0,
  input  logic [ADDR_WIDTH-1:0]          pc1,
  input  logic [ID_WIDTH-1:0]            id0,
  input  logic [ID_WIDTH-1:0]            id1,
  output logic                           stall,
  output logic [$clog2(NUM_ENTRIES):0]   free,
  output logic                           lane0_valid,
  output logic [INST_WIDTH-1:0]          lane0_inst,
  output logic [ADDR_WIDTH-1:0]          lane0_pc,
  output logic [ID_WIDTH-1:0]            lane0_id,
  output logic                           lane1_valid,
  output logic [INST_WIDTH-1:0]          lane1_inst,
  output logic [ADDR_WIDTH-1:0]          lane1_pc,
  output logic [ID_WIDTH-1:0]            lane1_id
);

  localparam int KEY_W  = $clog2(NUM_ENTRIES);
  localparam int DATA_W = INST_WIDTH + ADDR_WIDTH + ID_WIDTH;
  localparam int MASK_W = $bits(reg_mask_t);
  localparam int PIPE_W = $bits(pipe_t);

  logic [NUM_ENTRIES*INST_WIDTH-1:0] slot_inst;
  logic [NUM_ENTRIES*ADDR_WIDTH-1:0] slot_pc;
  logic [NUM_ENTRIES*ID_WIDTH-1:0]   slot_id;
  logic [NUM_ENTRIES-1:0]            slot_valid;
  logic [NUM_ENTRIES*REG_BITS-1:0]   src0;
  logic [NUM_ENTRIES*REG_BITS-1:0]   src1;
  logic [NUM_ENTRIES*REG_BITS-1:0]   dest;
  logic [NUM_ENTRIES*MASK_W-1:0]     mask;
  logic [NUM_ENTRIES*PIPE_W-1:0]     pipe;
  logic [NUM_ENTRIES-1:0]            eligible;
  logic                              pop0;
  logic                              pop1;
  logic [KEY_W-1:0]                  pop_key0;
  logic [KEY_W-1:0]                  pop_key1;
  logic                              first;
  logic [DATA_W:0]                   pick0;  // {valid, inst, pc, id}.
  logic [DATA_W:0]                   pick1;
  logic [DATA_W:0]                   lane0_q;
  logic [DATA_W:0]                   lane1_q;

  issue_entry_store #(.NUM_ENTRIES(NUM_ENTRIES)) u_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .push0      (push0),
    .push1      (push1),
    .push_data0 ({inst0, pc0, id0}),
    .push_data1 ({inst1, pc1, id1}),
    .pop0       (pop0),
    .pop_key0   (pop_key0),
    .pop1       (pop1),
    .pop_key1   (pop_key1),
    .slot_inst  (slot_inst),
    .slot_pc    (slot_pc),
    .slot_id    (slot_id),
    .slot_valid (slot_valid),
    .free       (free),
    .stall      (stall)
  );

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_decode
    reg_decode u_decode (
      .inst (slot_inst[g*INST_WIDTH +: INST_WIDTH]),
      .src0 (src0[g*REG_BITS +: REG_BITS]),
      .src1 (src1[g*REG_BITS +: REG_BITS]),
      .dest (dest[g*REG_BITS +: REG_BITS]),
      .mask (mask[g*MASK_W +: MASK_W]),
      .pipe (pipe[g*PIPE_W +: PIPE_W])
    );
  end

  pair_hazard #(.NUM_ENTRIES(NUM_ENTRIES)) u_hazard (
    .slot_inst  (slot_inst),
    .src0       (src0),
    .src1       (src1),
    .dest       (dest),
    .mask       (mask),
    .slot_valid (slot_valid),
    .pop0       (pop0),
    .pop_key0   (pop_key0),
    .eligible   (eligible)
  );

  issue_select #(.NUM_ENTRIES(NUM_ENTRIES)) u_select (
    .clk        (clk),
    .rst_n      (rst_n),
    .slot_valid (slot_valid),
    .eligible   (eligible),
    .pipe       (pipe),
    .pop0       (pop0),
    .pop_key0   (pop_key0),
    .pop1       (pop1),
    .pop_key1   (pop_key1),
    .first      (first)
  );

  //////////////////////////////
  // lane registers.

  assign pick0 = pop0 ? {1'b1, slot_inst[pop_key0*INST_WIDTH +: INST_WIDTH],
                         slot_pc[pop_key0*ADDR_WIDTH +: ADDR_WIDTH],
                         slot_id[pop_key0*ID_WIDTH +: ID_WIDTH]} : '0;
  assign pick1 = pop1 ? {1'b1, slot_inst[pop_key1*INST_WIDTH +: INST_WIDTH],
                         slot_pc[pop_key1*ADDR_WIDTH +: ADDR_WIDTH],
                         slot_id[pop_key1*ID_WIDTH +: ID_WIDTH]} : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane0_q <= '0;
      lane1_q <= '0;
    end else if (flush) begin
      lane0_q <= '0;
      lane1_q <= '0;
    end else if (first) begin  // oldest on the memory lane.
      lane0_q <= pick1;
      lane1_q <= pick0;
    end else begin
      lane0_q <= pick0;
      lane1_q <= pick1;
    end
  end

  assign {lane0_valid, lane0_inst, lane0_pc, lane0_id} = lane0_q;
  assign {lane1_valid, lane1_inst, lane1_pc, lane1_id} = lane1_q;

endmodule

`default_nettype wire

//--- dv/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

typedef struct packed {
  logic [INST_WIDTH-1:0] inst;
  logic [ADDR_WIDTH-1:0] pc;
  logic [ID_WIDTH-1:0]   id;
} entry_t;

entry_t                  mq[$];  // index 0 is the oldest.
logic [$bits(entry_t):0] exp_lane0;  // {valid, inst, pc, id}.
logic [$bits(entry_t):0] exp_lane1;
logic [3:0]              exp_free;
logic                    exp_stall;

// {rd, rs1, rs0} live bits.
function automatic logic [2:0] used_fields(logic [31:0] w);
  logic [5:0] op;
  op = w[31:26];
  case (op[5:4])
    2'b00:   return (op == OP_NOP) ? 3'b000 : 3'b111;
    2'b01:   return 3'b101;
    2'b10:   return (op == OP_LW) ? 3'b101 : (op == OP_SW) ? 3'b011 : 3'b000;
    default: return 3'b000;
  endcase
endfunction

function automatic logic [4:0] dest_of(logic [31:0] w);
  return (w[31:30] == 2'b00) ? w[15:11] : w[20:16];
endfunction

function automatic logic reads_reg(logic [31:0] w, logic [4:0] r);
  logic [2:0] m;
  m = used_fields(w);
  return (m[0] && w[25:21] == r) || (m[1] && w[20:16] == r);
endfunction

function automatic logic is_cmp_op(logic [31:0] w);
  return w[31:26] inside {OP_CMP, OP_TEST, OP_CMPI, OP_TESTI};
endfunction

function automatic logic is_branch_op(logic [31:0] w);
  return w[31:30] == 2'b11 && w[31:26] != OP_JMP;
endfunction

function automatic logic is_mem_op(logic [31:0] w);
  return w[31:26] inside {OP_LW, OP_SW};
endfunction

function automatic pipe_t pipe_class(logic [31:0] w);
  if (w[31:30] == 2'b10) return PIPE_MEMORY;
  if (w[31:30] == 2'b11 || is_cmp_op(w)) return PIPE_BRANCH;
  return PIPE_ANY;
endfunction

function automatic logic older_blocks(logic [31:0] o, logic [31:0] y, logic o_first);
  logic [2:0] mo;
  logic [2:0] my;
  logic       raw;
  logic       war;
  logic       waw;
  mo  = used_fields(o);
  my  = used_fields(y);
  raw = mo[2] && reads_reg(y, dest_of(o));
  war = my[2] && reads_reg(o, dest_of(y));
  waw = mo[2] && my[2] && dest_of(o) == dest_of(y);
  return raw || (!o_first && (war || waw || is_branch_op(o))) ||
         (is_branch_op(y) && is_cmp_op(o)) || (is_cmp_op(y) && is_branch_op(o)) ||
         (is_mem_op(y) && is_mem_op(o));
endfunction

// entry k may go second next to the oldest.
function automatic logic second_ok(int k, pipe_t p0);
  pipe_t pk;
  pk = pipe_class(mq[k].inst);
  if (p0 != PIPE_ANY && p0 == pk) return 1'b0;
  for (int j = 0; j < k; j++) begin
    if (older_blocks(mq[j].inst, mq[k].inst, j == 0)) return 1'b0;
  end
  return 1'b1;
endfunction

task automatic model_reset();
  mq.delete();
  exp_lane0 = '0;
  exp_lane1 = '0;
  exp_free  = 4'd8;
  exp_stall = 1'b0;
endtask

task automatic model_step(input logic fl, input logic p0, input logic p1,
                          input entry_t e0, input entry_t e1);
  int                      k1;
  pipe_t                   q0;
  pipe_t                   q1;
  logic                    swap;
  logic [$bits(entry_t):0] pick0;
  logic [$bits(entry_t):0] pick1;
  k1    = 0;
  swap  = 1'b0;
  pick0 = '0;
  pick1 = '0;
  if (fl) begin
    mq.delete();
  end else if (mq.size() > 0) begin
    q0 = pipe_class(mq[0].inst);
    for (int k = 1; k < mq.size() && k1 == 0; k++) begin
      if (second_ok(k, q0)) k1 = k;
    end
    pick0 = {1'b1, mq[0]};
    swap  = (q0 == PIPE_MEMORY);  // lone memory op on lane 1.
    if (k1 != 0) begin
      q1    = pipe_class(mq[k1].inst);
      pick1 = {1'b1, mq[k1]};
      swap  = swap || (q0 == PIPE_ANY && q1 == PIPE_BRANCH);
      mq.delete(k1);
    end
    mq.delete(0);
  end
  if (!fl && p0) mq.push_back(e0);
  if (!fl && p1) mq.push_back(e1);
  exp_lane0 = swap ? pick1 : pick0;
  exp_lane1 = swap ? pick0 : pick1;
  exp_free  = 4'(8 - mq.size());
  exp_stall = exp_free < 4'd2;
endtask

`endif

//--- dv/tb_issue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_issue import issue_pkg::*; ();

  localparam logic [5:0] OP_ADD = 6'b000001;
  localparam logic [5:0] OP_BEQ = 6'b110001;
  localparam logic [5:0] NAMED_OPS [8] = '{OP_NOP, OP_CMP, OP_TEST, OP_CMPI,
                                           OP_TESTI, OP_LW, OP_SW, OP_JMP};

  localparam int RESET_CYCLES  = 5;
  localparam int DIRECT_CYCLES = 2 + 5 + 8 + 12 + 6;
  localparam int DRAIN_CYCLES  = 5 * 16;
  localparam int RANDOM_CYCLES = 400;
  localparam int MAX_CYCLES    = RESET_CYCLES + DIRECT_CYCLES + DRAIN_CYCLES +
                                 RANDOM_CYCLES + 50;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  flush;
  logic                  push0;
  logic                  push1;
  logic [INST_WIDTH-1:0] inst0;
  logic [INST_WIDTH-1:0] inst1;
  logic [ADDR_WIDTH-1:0] pc0;
  logic [ADDR_WIDTH-1:0] pc1;
  logic [ID_WIDTH-1:0]   id0;
  logic [ID_WIDTH-1:0]   id1;
  logic                  stall;
  logic [3:0]            free;
  logic                  lane0_valid;
  logic [INST_WIDTH-1:0] lane0_inst;
  logic [ADDR_WIDTH-1:0] lane0_pc;
  logic [ID_WIDTH-1:0]   lane0_id;
  logic                  lane1_valid;
  logic [INST_WIDTH-1:0] lane1_inst;
  logic [ADDR_WIDTH-1:0] lane1_pc;
  logic [ID_WIDTH-1:0]   lane1_id;

  int          errors    = 0;
  int          checks    = 0;
  int          test_base = 0;
  int          cycles    = 0;
  logic [15:0] lfsr      = 16'd61;
  logic [7:0]  id_ctr    = 8'h10;

  `include "issue_model.svh"

  issue_top #(.NUM_ENTRIES(8)) UUT (
    .clk (clk), .rst_n (rst_n), .flush (flush), .push0 (push0), .push1 (push1),
    .inst0 (inst0), .inst1 (inst1), .pc0 (pc0), .pc1 (pc1), .id0 (id0), .id1 (id1),
    .stall (stall), .free (free),
    .lane0_valid (lane0_valid), .lane0_inst (lane0_inst),
    .lane0_pc (lane0_pc), .lane0_id (lane0_id),
    .lane1_valid (lane1_valid), .lane1_inst (lane1_inst),
    .lane1_pc (lane1_pc), .lane1_id (lane1_id)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // helpers.

  function automatic logic [31:0] rand_bits(input int n);  // x^16+x^14+x^13+x^11+1.
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] rand_inst();
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [10:0] rest;
    if (rand_bits(1) == 32'd1) op = NAMED_OPS[rand_bits(3)];
    else op = 6'(rand_bits(6));
    rs   = 5'(rand_bits(3));  // few registers, many hazards.
    rt   = 5'(rand_bits(3));
    rd   = 5'(rand_bits(3));
    rest = 11'(rand_bits(11));
    return {op, rs, rt, rd, rest};
  endfunction

  function automatic logic [31:0] make_inst(logic [5:0] op, logic [4:0] rs,
                                            logic [4:0] rt, logic [4:0] rd);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic compare_outputs();
    check("free", free, exp_free);
    check("stall", stall, exp_stall);
    check("lane0_valid", lane0_valid, exp_lane0[72]);
    check("lane0_inst", lane0_inst, exp_lane0[71:40]);
    check("lane0_pc", lane0_pc, exp_lane0[39:8]);
    check("lane0_id", lane0_id, exp_lane0[7:0]);
    check("lane1_valid", lane1_valid, exp_lane1[72]);
    check("lane1_inst", lane1_inst, exp_lane1[71:40]);
    check("lane1_pc", lane1_pc, exp_lane1[39:8]);
    check("lane1_id", lane1_id, exp_lane1[7:0]);
  endtask

  // drive on the falling edge, compare after the next rising one.
  task automatic step(input logic fl, input logic p0, input logic p1,
                      input logic [31:0] i0, input logic [31:0] i1);
    flush  = fl;
    push0  = p0;
    push1  = p1;
    inst0  = i0;
    inst1  = i1;
    id0    = id_ctr;
    id1    = 8'(id_ctr + 1);
    pc0    = 32'h1000 + 32'(id0) * 4;
    pc1    = 32'h1000 + 32'(id1) * 4;
    id_ctr = 8'(id_ctr + 2);
    model_step(fl, p0, p1, {i0, pc0, id0}, {i1, pc1, id1});
    @(posedge clk);
    @(negedge clk);
    compare_outputs();
  endtask

  task automatic drain();
    for (int n = 0; n < 16 && mq.size() > 0; n++) begin
      step(1'b0, 1'b0, 1'b0, '0, '0);
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s done, %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  //////////////////////////////
  // tests.

  initial begin
    logic [7:0]  base;
    logic        fl;
    logic        p0;
    logic        p1;
    logic [31:0] i0;
    logic [31:0] i1;
    rst_n = 1'b0;
    flush = 1'b0;
    push0 = 1'b0;
    push1 = 1'b0;
    inst0 = '0;
    inst1 = '0;
    pc0   = '0;
    pc1   = '0;
    id0   = '0;
    id1   = '0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_outputs();

    base = id_ctr;  // two independent alu ops.
    step(1'b0, 1'b1, 1'b1, make_inst(OP_ADD, 2, 3, 1), make_inst(OP_ADD, 5, 6, 4));
    step(1'b0, 1'b0, 1'b0, '0, '0);
    check("lane0_id", lane0_id, base);
    check("lane1_id", lane1_id, 8'(base + 1));
    check("lane0_pc", lane0_pc, 32'h1000 + 32'(base) * 4);
    finish_test("basic");

    base = id_ctr;
    step(1'b0, 1'b1, 1'b1, make_inst(OP_ADD, 2, 3, 1), make_inst(OP_ADD, 1, 5, 4));
    step(1'b0, 1'b0, 1'b0, '0, '0);
    check("lane1_valid", lane1_valid, 1'b0);
    step(1'b0, 1'b0, 1'b0, '0, '0);
    check("lane0_id", lane0_id, 8'(base + 1));
    base = id_ctr;  // waw, first pick issuing.
    step(1'b0, 1'b1, 1'b1, make_inst(OP_ADD, 2, 3, 1), make_inst(OP_ADD, 4, 5, 1));
    step(1'b0, 1'b0, 1'b0, '0, '0);
    check("lane1_valid", lane1_valid, 1'b1);
    check("lane1_id", lane1_id, 8'(base + 1));
    finish_test("hazard");

    base = id_ctr;
    step(1'b0, 1'b1, 1'b1, make_inst(OP_LW, 2, 7, 0), make_inst(OP_BEQ, 0, 0, 0));
    step(1'b0, 1'b0, 1'b0, '0, '0);
    check("lane1_id", lane1_id, base);
    check("lane0_id", lane0_id, 8'(base + 1));
    step(1'b0, 1'b1, 1'b1, make_inst(OP_LW, 2, 7, 0), make_inst(OP_LW, 3, 6, 0));
    step(1'b0, 1'b0, 1'b0, '0, '0);
    check("lane0_valid", lane0_valid, 1'b0);
    drain();
    step(1'b0, 1'b1, 1'b1, make_inst(OP_BEQ, 0, 0, 0), make_inst(OP_BEQ, 0, 0, 0));
    step(1'b0, 1'b0, 1'b0, '0, '0);
    check("lane1_valid", lane1_valid, 1'b0);
    drain();
    finish_test("steer");

    for (int n = 0; n < 12 && !exp_stall; n++) begin  // every entry reads r1.
      step(1'b0, 1'b1, 1'b1, make_inst(OP_ADD, 1, 1, 1), make_inst(OP_ADD, 1, 1, 1));
    end
    check("stall", stall, 1'b1);
    finish_test("fill");

    while (exp_stall) begin
      step(1'b0, 1'b0, 1'b0, '0, '0);
    end
    step(1'b1, 1'b1, 1'b1, make_inst(OP_ADD, 2, 3, 1), make_inst(OP_ADD, 5, 6, 4));
    check("free", free, 4'd8);
    step(1'b0, 1'b0, 1'b0, '0, '0);
    check("lane0_valid", lane0_valid, 1'b0);
    finish_test("flush");

    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      fl = (rand_bits(5) == 32'd0);
      p0 = !exp_stall && rand_bits(1) == 32'd1;
      p1 = !exp_stall && rand_bits(1) == 32'd1;
      i0 = rand_inst();
      i1 = rand_inst();
      step(fl, p0, p1, i0, i1);
    end
    finish_test("random");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
verilog/issue_pkg.sv
verilog/issue_entry_store.sv
verilog/reg_decode.sv
verilog/pair_hazard.sv
verilog/issue_select.sv
verilog/issue_top.sv
dv/tb_issue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_issue -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_issue)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
